//--- include/chipset_defs.svh
/*
 * Chipset start and reset levels shared by the RTL and the testbench
 */
`ifndef CHIPSET_DEFS_SVH
`define CHIPSET_DEFS_SVH

`define TIMER_START_LEVEL 1'b1
`define READY_RESET_LEVEL 1'b0

`endif

//--- hdl/chipset_pkg.sv
/*
 * Chipset package
 * Bus types and default parameter values for the XT bus-cycle core
 */
`default_nettype none

package chipset_pkg;

    localparam int DMA_CHANNELS = 4;

    // Refresh period in clocks, even so both halves match
    localparam logic [15:0] DEFAULT_REFRESH_DIVISOR = 16'd18;
    localparam int DEFAULT_DMA_CYCLE_LENGTH = 4;

    typedef logic [7:0] data_t;
    typedef logic [DMA_CHANNELS-1:0] dma_vec_t;

    // Bus commands, all active low
    typedef struct packed {
        logic io_read_n;
        logic io_write_n;
        logic memory_read_n;
        logic memory_write_n;
    } bus_cmd_t;

    // Read data offered by the chipset and by RAM
    typedef struct packed {
        data_t chipset_data;
        logic  chipset_drive;
        data_t ram_data;
        logic  ram_select_n;
    } data_src_t;

endpackage

`default_nettype wire

//--- hdl/refresh_timer.sv
/*
 * Refresh timer
 * Reloading down-counter giving a square wave, like timer channel 1
 * in square-wave mode
 */
`timescale 1ns/1ps
`default_nettype none
`include "chipset_defs.svh"

module refresh_timer #(
    parameter logic [15:0] REFRESH_DIVISOR = chipset_pkg::DEFAULT_REFRESH_DIVISOR
) (
    input  logic clock,
    input  logic reset,
    output logic timer_out
);

    localparam logic [15:0] HALF_DIVISOR = REFRESH_DIVISOR >> 1;

    logic [15:0] count;
    logic [15:0] count_next;

    // Reload on reaching 1
    assign count_next = (count == 16'd1) ? REFRESH_DIVISOR : count - 16'd1;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count     <= REFRESH_DIVISOR;
            timer_out <= `TIMER_START_LEVEL;
        end else begin
            count     <= count_next;
            // High through the upper half of the count
            timer_out <= (count_next > HALF_DIVISOR);
        end
    end

    timer_edge_points: assert property (
        @(posedge clock) disable iff (reset)
        $changed(timer_out) |-> (count == REFRESH_DIVISOR || count == HALF_DIVISOR)
    ) else $error("timer_out changed away from reload or half count");

endmodule

`default_nettype wire

//--- hdl/dma_cycle_fsm.sv
/*
 * DMA cycle FSM
 * Latches the refresh request on channel 0, grants the highest priority
 * channel once the bus is idle and holds processor ready off meanwhile
 */
`timescale 1ns/1ps
`default_nettype none
`include "chipset_defs.svh"

module dma_cycle_fsm #(
    parameter int DMA_CYCLE_LENGTH = chipset_pkg::DEFAULT_DMA_CYCLE_LENGTH
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  timer_out,
    input  logic [2:0]            dma_request,
    input  chipset_pkg::bus_cmd_t bus_cmd,
    input  logic                  io_channel_ready,
    output chipset_pkg::dma_vec_t dma_acknowledge_n,
    output logic                  address_enable_n,
    output logic                  processor_ready
);

    import chipset_pkg::*;

    localparam int CHANNEL_W = $clog2(DMA_CHANNELS);
    localparam int COUNT_W   = $clog2(DMA_CYCLE_LENGTH + 1);
    localparam logic [COUNT_W-1:0] LAST_COUNT = COUNT_W'(DMA_CYCLE_LENGTH - 1);

    typedef enum logic [1:0] {
        IDLE,
        GRANT,
        ACTIVE
    } dma_state_t;

    dma_state_t           state;
    dma_state_t           state_next;
    logic                 prev_timer_out;
    logic                 refresh_request;
    dma_vec_t             requests;
    logic [CHANNEL_W-1:0] pick;
    logic [CHANNEL_W-1:0] channel;
    logic [COUNT_W-1:0]   cycle_count;
    logic                 bus_idle;

    // Refresh request, set after a timer rise and cleared by its acknowledge
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            prev_timer_out  <= `TIMER_START_LEVEL;
            refresh_request <= 1'b0;
        end else begin
            prev_timer_out <= timer_out;
            if (~dma_acknowledge_n[0])
                refresh_request <= 1'b0;
            else if (timer_out & ~prev_timer_out)
                refresh_request <= 1'b1;
        end
    end

    assign requests = {dma_request, refresh_request};

    assign bus_idle = bus_cmd.io_read_n & bus_cmd.io_write_n
                    & bus_cmd.memory_read_n & bus_cmd.memory_write_n;

    // Channel 0 wins
    always_comb begin
        pick = '0;
        for (int i = DMA_CHANNELS - 1; i >= 0; i--) begin
            if (requests[i])
                pick = CHANNEL_W'(i);
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (|requests)
                    state_next = GRANT;
            end
            GRANT: begin
                if (bus_idle)
                    state_next = ACTIVE;
            end
            ACTIVE: begin
                if (cycle_count == LAST_COUNT)
                    state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state           <= IDLE;
            channel         <= '0;
            cycle_count     <= '0;
            processor_ready <= `READY_RESET_LEVEL;
        end else begin
            state <= state_next;
            if (state == IDLE)
                channel <= pick;
            if (state == ACTIVE)
                cycle_count <= cycle_count + COUNT_W'(1);
            else
                cycle_count <= '0;
            // Ready drops in the same clock the grant starts
            processor_ready <= (state_next == IDLE) & io_channel_ready;
        end
    end

    assign address_enable_n = (state == IDLE);

    always_comb begin
        dma_acknowledge_n = '1;
        if (state == ACTIVE)
            dma_acknowledge_n[channel] = 1'b0;
    end

    single_ack: assert property (
        @(posedge clock) disable iff (reset)
        $onehot0(~dma_acknowledge_n)
    ) else $error("more than one DMA acknowledge low");

    ack_within_aen: assert property (
        @(posedge clock) disable iff (reset)
        address_enable_n |-> (&dma_acknowledge_n)
    ) else $error("DMA acknowledge low while address_enable_n high");

endmodule

`default_nettype wire

//--- hdl/data_bus_steer.sv
/*
 * Data bus steering
 * Picks the internal data bus source: chipset, then RAM, then external
 */
`timescale 1ns/1ps
`default_nettype none

module data_bus_steer (
    input  chipset_pkg::data_src_t data_src,
    input  logic                   memory_read_n,
    input  chipset_pkg::data_t     data_bus_ext,
    input  logic                   cpu_read_ext,
    output chipset_pkg::data_t     internal_data_bus,
    output logic                   data_bus_direction
);

    always_comb begin
        if (data_src.chipset_drive) begin
            internal_data_bus  = data_src.chipset_data;
            data_bus_direction = 1'b0;
        end else if (~data_src.ram_select_n && ~memory_read_n) begin
            internal_data_bus  = data_src.ram_data;
            data_bus_direction = 1'b0;
        end else if (cpu_read_ext) begin
            // Only inbound case
            internal_data_bus  = data_bus_ext;
            data_bus_direction = 1'b1;
        end else begin
            internal_data_bus  = '0;
            data_bus_direction = 1'b0;
        end

        chipset_drive_outbound: assert (!(data_src.chipset_drive && data_bus_direction))
            else $error("bus direction inbound while chipset drives");
    end

endmodule

`default_nettype wire

//--- hdl/chipset_top.sv
/*
 * Chipset top level
 * Refresh timer, DMA cycle FSM and data bus steering of the XT core
 */
`timescale 1ns/1ps
`default_nettype none

module chipset_top #(
    parameter logic [15:0] REFRESH_DIVISOR  = chipset_pkg::DEFAULT_REFRESH_DIVISOR,
    parameter int          DMA_CYCLE_LENGTH = chipset_pkg::DEFAULT_DMA_CYCLE_LENGTH
) (
    input  logic                   clock,
    input  logic                   reset,
    // Bus commands and ready
    input  chipset_pkg::bus_cmd_t  bus_cmd,
    input  logic                   io_channel_ready,
    // Channels 3 to 1
    input  logic [2:0]             dma_request,
    // Read data sources
    input  chipset_pkg::data_src_t data_src,
    input  chipset_pkg::data_t     data_bus_ext,
    input  logic                   cpu_read_ext,
    output chipset_pkg::data_t     internal_data_bus,
    output logic                   data_bus_direction,
    // Refresh and DMA
    output logic                   timer_out,
    output chipset_pkg::dma_vec_t  dma_acknowledge_n,
    output logic                   address_enable_n,
    output logic                   processor_ready
);

    refresh_timer #(
        .REFRESH_DIVISOR (REFRESH_DIVISOR)
    ) u_refresh_timer (
        .clock     (clock),
        .reset     (reset),
        .timer_out (timer_out)
    );

    dma_cycle_fsm #(
        .DMA_CYCLE_LENGTH (DMA_CYCLE_LENGTH)
    ) u_dma_cycle_fsm (
        .clock             (clock),
        .reset             (reset),
        .timer_out         (timer_out),
        .dma_request       (dma_request),
        .bus_cmd           (bus_cmd),
        .io_channel_ready  (io_channel_ready),
        .dma_acknowledge_n (dma_acknowledge_n),
        .address_enable_n  (address_enable_n),
        .processor_ready   (processor_ready)
    );

    data_bus_steer u_data_bus_steer (
        .data_src           (data_src),
        .memory_read_n      (bus_cmd.memory_read_n),
        .data_bus_ext       (data_bus_ext),
        .cpu_read_ext       (cpu_read_ext),
        .internal_data_bus  (internal_data_bus),
        .data_bus_direction (data_bus_direction)
    );

endmodule

`default_nettype wire

//--- verif/tb_chipset.sv
/*
 * Chipset testbench
 * Refresh timing, DMA grant order, ready gating and random data bus steering
 */
`timescale 1ns/1ps
`default_nettype none
`include "chipset_defs.svh"

module tb_chipset;

    import chipset_pkg::*;

    localparam logic [15:0] REFRESH_DIVISOR  = DEFAULT_REFRESH_DIVISOR;
    localparam int          PERIOD           = int'(REFRESH_DIVISOR);
    localparam int          DMA_CYCLE_LENGTH = DEFAULT_DMA_CYCLE_LENGTH;
    localparam int          RANDOM_VECTORS   = 300;
    // Forty refresh periods leave room over the longest run
    localparam int          TIMEOUT_CYCLES   = 40 * PERIOD + 100;

    logic       clock;
    logic       reset;
    bus_cmd_t   bus_cmd;
    logic       io_channel_ready;
    logic [2:0] dma_request;
    data_src_t  data_src;
    data_t      data_bus_ext;
    logic       cpu_read_ext;
    data_t      internal_data_bus;
    logic       data_bus_direction;
    logic       timer_out;
    dma_vec_t   dma_acknowledge_n;
    logic       address_enable_n;
    logic       processor_ready;

    int          seed = 26330;
    logic [31:0] rand_word;
    int          cycle;
    int          steer_errors;
    int          cycle_errors;
    int          sequence_errors;
    int          last_rise;
    int          ack_run [DMA_CHANNELS];
    int          ack_done [DMA_CHANNELS];
    logic        prev_timer;
    logic        prev_ready_in;
    dma_vec_t    prev_ack;
    bus_cmd_t    prev_bus_cmd;
    logic        expected_ready;
    logic [8:0]  expected_bus;

    chipset_top #(
        .REFRESH_DIVISOR  (REFRESH_DIVISOR),
        .DMA_CYCLE_LENGTH (DMA_CYCLE_LENGTH)
    ) uut (
        .clock              (clock),
        .reset              (reset),
        .bus_cmd            (bus_cmd),
        .io_channel_ready   (io_channel_ready),
        .dma_request        (dma_request),
        .data_src           (data_src),
        .data_bus_ext       (data_bus_ext),
        .cpu_read_ext       (cpu_read_ext),
        .internal_data_bus  (internal_data_bus),
        .data_bus_direction (data_bus_direction),
        .timer_out          (timer_out),
        .dma_acknowledge_n  (dma_acknowledge_n),
        .address_enable_n   (address_enable_n),
        .processor_ready    (processor_ready)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock or posedge reset) begin
        if (reset)
            cycle <= 0;
        else
            cycle <= cycle + 1;
    end

    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("timeout after %0d clocks with tests still running", cycle);
        $display("Test failed");
        $finish;
    end

    // Direction in the top bit, bus byte below
    function automatic logic [8:0] expected_steering(input data_src_t src, input logic mem_rd_n,
                                                     input data_t ext, input logic cpu_rd);
        logic [8:0] result;
        result = 9'd0;
        if (src.chipset_drive)
            result = {1'b0, src.chipset_data};
        else if (!src.ram_select_n && !mem_rd_n)
            result = {1'b0, src.ram_data};
        else if (cpu_rd)
            result = {1'b1, ext};
        return result;
    endfunction

    always @(negedge clock) begin
        expected_bus = expected_steering(data_src, bus_cmd.memory_read_n, data_bus_ext,
                                         cpu_read_ext);
        if ({data_bus_direction, internal_data_bus} != expected_bus) begin
            steer_errors++;
            $display("mismatch at %0t: bus %h dir %b, expected bus %h dir %b", $time,
                     internal_data_bus, data_bus_direction, expected_bus[7:0], expected_bus[8]);
        end
    end

    always @(negedge clock) begin
        if (reset) begin
            if (dma_acknowledge_n != '1 || !address_enable_n
                    || processor_ready != `READY_RESET_LEVEL
                    || timer_out != `TIMER_START_LEVEL) begin
                cycle_errors++;
                $display("mismatch at %0t: in reset ack_n %b aen_n %b ready %b timer %b", $time,
                         dma_acknowledge_n, address_enable_n, processor_ready, timer_out);
            end
            last_rise = 0;
            for (int ch = 0; ch < DMA_CHANNELS; ch++)
                ack_run[ch] = 0;
        end else begin
            if (timer_out && !prev_timer) begin
                if (cycle - last_rise != PERIOD) begin
                    cycle_errors++;
                    $display("mismatch at %0t: timer rise after %0d clocks, expected %0d",
                             $time, cycle - last_rise, PERIOD);
                end
                last_rise = cycle;
            end
            if (cycle == 0)
                expected_ready = `READY_RESET_LEVEL;
            else if (!address_enable_n)
                expected_ready = 1'b0;
            else
                expected_ready = prev_ready_in;
            if (processor_ready != expected_ready) begin
                cycle_errors++;
                $display("mismatch at %0t: processor_ready %b, expected %b", $time,
                         processor_ready, expected_ready);
            end
            if (!$onehot0(~dma_acknowledge_n) || (dma_acknowledge_n != '1 && address_enable_n)) begin
                cycle_errors++;
                $display("mismatch at %0t: ack_n %b with aen_n %b", $time, dma_acknowledge_n,
                         address_enable_n);
            end
            // Grant may start only on an idle bus, and aen_n rises with the acknowledge
            if (prev_ack == '1 && dma_acknowledge_n != '1 && prev_bus_cmd != '1) begin
                cycle_errors++;
                $display("mismatch at %0t: acknowledge began with bus command %b", $time,
                         prev_bus_cmd);
            end
            if (prev_ack != '1 && dma_acknowledge_n == '1 && !address_enable_n) begin
                cycle_errors++;
                $display("mismatch at %0t: aen_n still low after acknowledge ended", $time);
            end
            for (int ch = 0; ch < DMA_CHANNELS; ch++) begin
                if (!dma_acknowledge_n[ch]) begin
                    ack_run[ch]++;
                end else if (ack_run[ch] != 0) begin
                    if (ack_run[ch] != DMA_CYCLE_LENGTH) begin
                        cycle_errors++;
                        $display("mismatch at %0t: channel %0d acknowledge lasted %0d clocks",
                                 $time, ch, ack_run[ch]);
                    end
                    ack_done[ch]++;
                    ack_run[ch] = 0;
                end
            end
        end
        prev_timer    = timer_out;
        prev_ready_in = io_channel_ready;
        prev_ack      = dma_acknowledge_n;
        prev_bus_cmd  = bus_cmd;
    end

    // Rising edge with a fresh random ready level
    task automatic next_edge;
        @(posedge clock);
        rand_word = $random(seed);
        io_channel_ready <= rand_word[0];
    endtask

    task automatic wait_refresh(input int pulses);
        int target;
        int waited;
        target = ack_done[0] + pulses;
        waited = 0;
        while (ack_done[0] < target && waited < (pulses + 2) * PERIOD) begin
            next_edge();
            waited++;
        end
        if (ack_done[0] < target) begin
            sequence_errors++;
            $display("refresh acknowledge missing after %0d clocks", waited);
        end
    endtask

    task automatic held_command;
        @(negedge clock);
        while (timer_out) begin
            next_edge();
            @(negedge clock);
        end
        while (!timer_out) begin
            next_edge();
            @(negedge clock);
        end
        next_edge();
        bus_cmd.io_write_n <= 1'b0;
        for (int i = 0; i < 7; i++) begin
            next_edge();
            @(negedge clock);
            if (dma_acknowledge_n != '1 || address_enable_n) begin
                sequence_errors++;
                $display("mismatch at %0t: ack_n %b aen_n %b while bus command held", $time,
                         dma_acknowledge_n, address_enable_n);
            end
        end
        next_edge();
        bus_cmd.io_write_n <= 1'b1;
        wait_refresh(1);
    endtask

    // Requester holds channels 1 and 3 until each sees its acknowledge
    task automatic two_channels;
        dma_vec_t acks;
        logic     first_seen;
        logic     last_seen;
        int       waited;
        wait_refresh(1);
        dma_request <= 3'b101;
        acks       = '1;
        first_seen = 1'b0;
        last_seen  = 1'b0;
        waited     = 0;
        while (!(last_seen && acks[3]) && waited < 4 * PERIOD) begin
            @(negedge clock);
            acks = dma_acknowledge_n;
            if (!acks[1])
                first_seen = 1'b1;
            if (!acks[3] && !last_seen) begin
                last_seen = 1'b1;
                if (!first_seen || dma_request[0]) begin
                    sequence_errors++;
                    $display("channel 3 acknowledged before channel 1 was served and dropped");
                end
            end
            next_edge();
            if (!acks[1])
                dma_request[0] <= 1'b0;
            if (!acks[3])
                dma_request[2] <= 1'b0;
            waited++;
        end
        if (!last_seen) begin
            sequence_errors++;
            $display("channel 3 was never acknowledged");
        end
    endtask

    task automatic random_steering;
        for (int i = 0; i < RANDOM_VECTORS; i++) begin
            next_edge();
            rand_word = $random(seed);
            data_src              <= data_src_t'(rand_word[17:0]);
            data_bus_ext          <= rand_word[25:18];
            cpu_read_ext          <= rand_word[26];
            bus_cmd.memory_read_n <= rand_word[27];
        end
        next_edge();
        data_src     <= '0;
        data_bus_ext <= '0;
        cpu_read_ext <= 1'b0;
        bus_cmd      <= '1;
    endtask

    initial begin
        reset            = 1'b1;
        bus_cmd          = '1;
        io_channel_ready = 1'b0;
        dma_request      = 3'b000;
        data_src         = '0;
        data_bus_ext     = '0;
        cpu_read_ext     = 1'b0;
        repeat (8) next_edge();
        reset <= 1'b0;
        wait_refresh(3);
        held_command();
        two_channels();
        random_steering();
        wait_refresh(1);
        $display("errors: %0d steering, %0d cycle, %0d sequence", steer_errors, cycle_errors,
                 sequence_errors);
        if (steer_errors + cycle_errors + sequence_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
hdl/chipset_pkg.sv
hdl/refresh_timer.sv
hdl/dma_cycle_fsm.sv
hdl/data_bus_steer.sv
hdl/chipset_top.sv
verif/tb_chipset.sv

//--- run.sh
#!/bin/sh
# Build and run the chipset testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_chipset -f verilog.f -o sim_chipset

output=$(./obj_dir/sim_chipset)
echo "$output"

if echo "$output" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1
